// ==== Makefile ====
SIM      = verilator
TOP      = tb_prog_ram_top
FILELIST = compile.f
VFLAGS   = --binary --timing --assert
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST)) hdl/ram_cfg.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/tb_prog_ram_top.sv ====
`timescale 1ns/1ps
`include "ram_cfg.svh"

module tb_prog_ram_top;

  localparam int DW    = `RAM_DATA_W;
  localparam int AW    = `RAM_ADDR_W;
  localparam int NB    = `RAM_NB_COL;
  localparam int CW    = `RAM_COL_W;
  localparam int DEPTH = 2 ** `RAM_ADDR_W;
  localparam int CPB   = `UART_CLKS_PER_BIT;
  localparam int GAP   = `PROG_BREAK_CYCLES + 200;

  logic             clk_i = 1'b0;
  logic             rst_ni;
  logic             rx_i;
  ram_pkg::mem_wr_t cpu_wr;
  ram_pkg::mem_rd_t cpu_rd;
  logic [DW-1:0]    rd_data;
  logic             prog_mode;
  logic             sys_rst_n;

  // Reference memory and stimulus state
  logic [DW-1:0] model_mem [DEPTH];
  logic [AW-1:0] cpu_addrs [$];
  logic [15:0]   lfsr_q = 16'd75;
  string         test_name;
  logic [DW-1:0] rd_exp;
  logic [AW-1:0] rd_addr;
  logic          rd_due;
  int            rd_errs = 0;
  int            chk_errs = 0;
  int            timeouts = 0;
  int            rst_lows = 0;
  int            mode_cycles = 0;

  always #50 clk_i = ~clk_i;

  prog_ram_top prog_ram_top_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rx_i        (rx_i),
    .cpu_wr_i    (cpu_wr),
    .cpu_rd_i    (cpu_rd),
    .rd_data_o   (rd_data),
    .prog_mode_o (prog_mode),
    .sys_rst_no  (sys_rst_n)
  );

  //////////////////////////////
  // Reference and random source
  //////////////////////////////

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int i;
    r = '0;
    for (i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_q[0]};
      lfsr_q = {1'b0, lfsr_q[15:1]} ^ (lfsr_q[0] ? 16'hB400 : 16'h0000);
    end
    return r;
  endfunction

  // Each byte lane lands under its own strobe bit
  function automatic void model_write(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                                      input logic [NB-1:0] strb);
    int c;
    for (c = 0; c < NB; c++) begin
      if (strb[c]) begin
        model_mem[addr][c*CW +: CW] = data[c*CW +: CW];
      end
    end
  endfunction

  //////////////////////////////
  // Drivers
  //////////////////////////////

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk_i);
  endtask

  task automatic drive_bit(input logic v);
    @(posedge clk_i);
    rx_i <= v;
    repeat (CPB - 1) @(posedge clk_i);
  endtask

  // 8N1 frame sent LSB first
  task automatic send_byte(input logic [7:0] b);
    int i;
    drive_bit(1'b0);
    for (i = 0; i < 8; i++) begin
      drive_bit(b[i]);
    end
    drive_bit(1'b1);
  endtask

  task automatic send_text(input string s);
    int i;
    for (i = 0; i < s.len(); i++) begin
      send_byte(s[i]);
    end
  endtask

  task automatic cpu_write(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                           input logic [NB-1:0] strb);
    @(posedge clk_i);
    cpu_wr <= '{addr: addr, data: data, strb: strb};
    @(posedge clk_i);
    cpu_wr.strb <= '0;
    model_write(addr, data, strb);
  endtask

  task automatic cpu_read(input logic [AW-1:0] addr);
    @(posedge clk_i);
    cpu_rd  <= '{en: 1'b1, addr: addr};
    rd_exp  <= model_mem[addr];
    rd_addr <= addr;
    @(posedge clk_i);
    cpu_rd.en <= 1'b0;
  endtask

  task automatic read_range(input int first, input int n);
    int i;
    for (i = 0; i < n; i++) begin
      cpu_read(AW'(first + i));
    end
  endtask

  task automatic wait_mode_high(input int limit);
    int n;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (prog_mode !== 1'b1 && n < limit);
    if (prog_mode !== 1'b1) begin
      $display("%s: prog_mode_o did not rise within %0d cycles", test_name, limit);
      timeouts++;
    end
  endtask

  task automatic wait_rst_low(input int limit);
    int n;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (sys_rst_n !== 1'b0 && n < limit);
    if (sys_rst_n !== 1'b0) begin
      $display("%s: sys_rst_no did not pulse low within %0d cycles", test_name, limit);
      timeouts++;
    end
  endtask

  // Magic then count MSB first then random words
  task automatic load_program(input string magic, input int count, input bit good,
                              input bit cpu_between);
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] s;
    int i;
    send_text(magic);
    send_byte(count[31:24]);
    send_byte(count[23:16]);
    send_byte(count[15:8]);
    send_byte(count[7:0]);
    if (good && count > 0) begin
      wait_mode_high(40);
    end
    for (i = 0; i < count; i++) begin
      w = rand_bits(32);
      send_byte(w[31:24]);
      // No loader write falls in the middle of a word
      if (cpu_between) begin
        @(negedge clk_i);
        if (prog_mode !== 1'b1) begin
          $display("%s: loader left programming before word %0d", test_name, i);
          chk_errs++;
        end
        a = rand_bits(AW - 1);
        d = rand_bits(32);
        s = rand_bits(NB);
        cpu_addrs.push_back({1'b1, a[AW-2:0]});
        cpu_write({1'b1, a[AW-2:0]}, d, s[NB-1:0]);
      end
      send_byte(w[23:16]);
      send_byte(w[15:8]);
      send_byte(w[7:0]);
      if (good) begin
        model_write(AW'(i), w, {NB{1'b1}});
      end
    end
    if (good) begin
      wait_rst_low(200);
    end
  endtask

  //////////////////////////////
  // Monitors and read checker
  //////////////////////////////

  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (!sys_rst_n) begin
        rst_lows <= rst_lows + 1;
      end
      if (prog_mode) begin
        mode_cycles <= mode_cycles + 1;
      end
    end
  end

  always @(posedge clk_i) begin
    rd_due <= cpu_rd.en;
  end

  // Data is due one cycle after the request
  always @(negedge clk_i) begin
    if (rd_due) begin
      if (rd_data !== rd_exp) begin
        $display("ERR %s addr %0d expected %h actual %h", test_name, rd_addr, rd_exp, rd_data);
        rd_errs <= rd_errs + 1;
      end
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    logic [AW-1:0] addrs [20];
    logic [31:0]   a;
    logic [31:0]   d;
    logic [31:0]   s;
    int            i;
    int            base_rst;
    int            base_mode;
    rst_ni    = 1'b0;
    rx_i      = 1'b1;
    cpu_wr    = '0;
    cpu_rd    = '0;
    test_name = "reset";
    for (i = 0; i < DEPTH; i++) begin
      model_mem[i] = '0;
    end
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    if ({sys_rst_n, prog_mode} !== 2'b10) begin
      $display("ERR %s expected %b actual %b", test_name, 2'b10, {sys_rst_n, prog_mode});
      chk_errs++;
    end

    test_name = "cpu_bytes";
    for (i = 0; i < 20; i++) begin
      a = rand_bits(AW);
      d = rand_bits(32);
      s = rand_bits(NB);
      addrs[i] = a[AW-1:0];
      cpu_write(a[AW-1:0], d, s[NB-1:0]);
    end
    for (i = 0; i < 20; i++) begin
      cpu_read(addrs[i]);
    end

    test_name = "load_six";
    base_rst  = rst_lows;
    load_program(`PROG_MAGIC, 6, 1'b1, 1'b0);
    idle_cycles(5);
    if (rst_lows - base_rst != 1) begin
      $display("ERR %s expected %0d actual %0d", test_name, 1, rst_lows - base_rst);
      chk_errs++;
    end
    read_range(0, 8);

    test_name = "bad_magic";
    base_rst  = rst_lows;
    base_mode = mode_cycles;
    load_program("TEKNOFESX", 2, 1'b0, 1'b0);
    idle_cycles(GAP);
    if (rst_lows != base_rst) begin
      $display("ERR %s reset cycles expected %0d actual %0d", test_name, 0,
               rst_lows - base_rst);
      chk_errs++;
    end
    if (mode_cycles != base_mode) begin
      $display("ERR %s mode cycles expected %0d actual %0d", test_name, 0,
               mode_cycles - base_mode);
      chk_errs++;
    end
    read_range(0, 8);

    // Abandoned magic before a full load from address 0
    test_name = "split_magic";
    base_rst  = rst_lows;
    send_text("TEKN");
    idle_cycles(GAP);
    load_program(`PROG_MAGIC, 3, 1'b1, 1'b0);
    idle_cycles(5);
    if (rst_lows - base_rst != 1) begin
      $display("ERR %s expected %0d actual %0d", test_name, 1, rst_lows - base_rst);
      chk_errs++;
    end
    read_range(0, 8);

    test_name = "cpu_during_load";
    base_rst  = rst_lows;
    load_program(`PROG_MAGIC, 4, 1'b1, 1'b1);
    idle_cycles(5);
    if (rst_lows - base_rst != 1) begin
      $display("ERR %s expected %0d actual %0d", test_name, 1, rst_lows - base_rst);
      chk_errs++;
    end
    read_range(0, 6);
    foreach (cpu_addrs[i]) begin
      cpu_read(cpu_addrs[i]);
    end

    test_name = "zero_count";
    base_rst  = rst_lows;
    base_mode = mode_cycles;
    load_program(`PROG_MAGIC, 0, 1'b1, 1'b0);
    idle_cycles(5);
    if (rst_lows - base_rst != 1) begin
      $display("ERR %s reset cycles expected %0d actual %0d", test_name, 1,
               rst_lows - base_rst);
      chk_errs++;
    end
    if (mode_cycles != base_mode) begin
      $display("ERR %s mode cycles expected %0d actual %0d", test_name, 0,
               mode_cycles - base_mode);
      chk_errs++;
    end
    read_range(0, 8);

    idle_cycles(4);
    $display("Errors: %0d read, %0d check, %0d timeout", rd_errs, chk_errs, timeouts);
    if (rd_errs + chk_errs + timeouts == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+hdl
hdl/ram_pkg.sv
hdl/prog_pkg.sv
hdl/uart_rx.sv
hdl/prog_loader.sv
hdl/prog_ram.sv
hdl/prog_ram_top.sv
bench/tb_prog_ram_top.sv

// ==== hdl/prog_loader.sv ====
`timescale 1ns/1ps
`include "ram_cfg.svh"

module prog_loader (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  prog_pkg::rx_byte_t byte_i,
  output ram_pkg::mem_wr_t   wr_o,
  output logic               prog_mode_o,
  output logic               sys_rst_no
);

  localparam int DW    = `RAM_DATA_W;
  localparam int SEQ_W = $clog2(`PROG_MAGIC_LEN);
  localparam int BRK_W = $clog2(`PROG_BREAK_CYCLES);

  prog_pkg::loader_state_e state_q;
  prog_pkg::magic_t        magic_q;
  logic [SEQ_W-1:0]        seq_cnt_q;
  logic [BRK_W-1:0]        brk_cnt_q;
  logic [1:0]              byte_cnt_q;
  logic [DW-1:0]           len_q;
  logic [DW-1:0]           word_q;
  logic [DW-1:0]           word_cnt_q;
  logic [`RAM_ADDR_W-1:0]  addr_q;
  logic                    wr_valid_q;
  logic [DW-1:0]           len_next;
  logic [DW-1:0]           word_next;

  // MSB first assembly
  assign len_next  = {len_q[DW-9:0], byte_i.data};
  assign word_next = {word_q[DW-9:0], byte_i.data};

  //////////////////////////////
  // Loader FSM
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q    <= prog_pkg::WAIT;
      seq_cnt_q  <= '0;
      brk_cnt_q  <= '0;
      byte_cnt_q <= '0;
      word_cnt_q <= '0;
      addr_q     <= '0;
      wr_valid_q <= 1'b0;
    end else begin
      wr_valid_q <= 1'b0;
      case (state_q)
        prog_pkg::WAIT: begin
          brk_cnt_q <= '0;
          if (byte_i.valid) begin
            seq_cnt_q <= SEQ_W'(1);
            state_q   <= prog_pkg::RECEIVE;
          end
        end
        prog_pkg::RECEIVE: begin
          if (byte_i.valid) begin
            brk_cnt_q <= '0;
            if (seq_cnt_q == SEQ_W'(`PROG_MAGIC_LEN - 1)) begin
              seq_cnt_q <= '0;
              state_q   <= prog_pkg::CHECK;
            end else begin
              seq_cnt_q <= seq_cnt_q + 1'b1;
            end
          end else if (brk_cnt_q == BRK_W'(`PROG_BREAK_CYCLES - 1)) begin
            // Line went quiet mid-sequence
            seq_cnt_q <= '0;
            state_q   <= prog_pkg::WAIT;
          end else begin
            brk_cnt_q <= brk_cnt_q + 1'b1;
          end
        end
        prog_pkg::CHECK: begin
          byte_cnt_q <= '0;
          word_cnt_q <= '0;
          state_q    <= (magic_q == `PROG_MAGIC) ? prog_pkg::LENGTH : prog_pkg::WAIT;
        end
        prog_pkg::LENGTH: begin
          if (byte_i.valid) begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
            if (&byte_cnt_q) begin
              state_q <= (len_next == '0) ? prog_pkg::FINISH : prog_pkg::PROGRAM;
            end
          end
        end
        prog_pkg::PROGRAM: begin
          if (byte_i.valid) begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
            if (&byte_cnt_q) begin
              wr_valid_q <= 1'b1;
              word_cnt_q <= word_cnt_q + 1'b1;
            end
          end
          // Address advances after each write
          if (wr_valid_q) begin
            addr_q <= addr_q + 1'b1;
            if (word_cnt_q == len_q) begin
              state_q <= prog_pkg::FINISH;
            end
          end
        end
        prog_pkg::FINISH: begin
          addr_q  <= '0;
          state_q <= prog_pkg::WAIT;
        end
        default: state_q <= prog_pkg::WAIT;
      endcase
    end
  end

  // Byte shift registers
  always_ff @(posedge clk_i) begin
    if (byte_i.valid) begin
      case (state_q)
        prog_pkg::WAIT, prog_pkg::RECEIVE: magic_q <= {magic_q[`PROG_MAGIC_LEN*8-9:0], byte_i.data};
        prog_pkg::LENGTH:                  len_q   <= len_next;
        prog_pkg::PROGRAM:                 word_q  <= word_next;
        default: ;
      endcase
    end
  end

  assign wr_o.addr   = addr_q;
  assign wr_o.data   = word_q;
  assign wr_o.strb   = {`RAM_NB_COL{wr_valid_q}};
  assign prog_mode_o = (state_q == prog_pkg::PROGRAM);
  assign sys_rst_no  = (state_q != prog_pkg::FINISH);

  // A word write lands while the FSM is still programming
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    |wr_o.strb |-> state_q == prog_pkg::PROGRAM);

  // Programming mode only follows a nonzero length capture
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(prog_mode_o) |-> $past(state_q) == prog_pkg::LENGTH);

  // System reset is a single-cycle pulse
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !sys_rst_no |=> sys_rst_no);

endmodule

// ==== hdl/prog_pkg.sv ====
`include "ram_cfg.svh"

package prog_pkg;

  //////////////////////////////
  // Serial byte stream
  //////////////////////////////

  // One received byte, valid is a single-cycle strobe
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } rx_byte_t;

  // Shift register holding the last magic-length bytes
  typedef logic [`PROG_MAGIC_LEN*8-1:0] magic_t;

  //////////////////////////////
  // Loader FSM
  //////////////////////////////

  // Neighbouring states differ in one bit
  typedef enum logic [2:0] {
    WAIT    = 3'b000,
    RECEIVE = 3'b001,
    CHECK   = 3'b011,
    LENGTH  = 3'b010,
    PROGRAM = 3'b110,
    FINISH  = 3'b100
  } loader_state_e;

endpackage

// ==== hdl/prog_ram.sv ====
`timescale 1ns/1ps
`include "ram_cfg.svh"

module prog_ram (
  input  logic                   clk_i,
  input  ram_pkg::mem_wr_t       cpu_wr_i,
  input  ram_pkg::mem_wr_t       prog_wr_i,
  input  ram_pkg::mem_rd_t       cpu_rd_i,
  output logic [`RAM_DATA_W-1:0] rd_data_o
);

  localparam int DEPTH = 2 ** `RAM_ADDR_W;
  localparam int COL_W = `RAM_COL_W;

  ram_pkg::mem_wr_t wr_sel;

  // Loader owns any cycle in which it writes
  assign wr_sel = (|prog_wr_i.strb) ? prog_wr_i : cpu_wr_i;

  //////////////////////////////
  // Byte columns
  //////////////////////////////

  for (genvar c = 0; c < `RAM_NB_COL; c++) begin : g_col
    logic [COL_W-1:0] col_mem [DEPTH];
    logic [COL_W-1:0] rd_col;

    // RAM comes up zeroed
    initial begin
      for (int i = 0; i < DEPTH; i++) begin
        col_mem[i] = '0;
      end
    end

    always_ff @(posedge clk_i) begin
      if (wr_sel.strb[c]) begin
        col_mem[wr_sel.addr] <= wr_sel.data[c*COL_W +: COL_W];
      end
    end

    // Registered read, holds when not enabled
    always_ff @(posedge clk_i) begin
      if (cpu_rd_i.en) begin
        rd_col <= col_mem[cpu_rd_i.addr];
      end
    end

    assign rd_data_o[c*COL_W +: COL_W] = rd_col;

    // Loader data survives a colliding CPU write
    assert property (@(posedge clk_i)
      prog_wr_i.strb[c] |=>
        col_mem[$past(prog_wr_i.addr)] == $past(prog_wr_i.data[c*COL_W +: COL_W]));
  end

  // Collisions where the CPU write is dropped
  cover property (@(posedge clk_i) (|prog_wr_i.strb) && (|cpu_wr_i.strb));

endmodule

// ==== hdl/prog_ram_top.sv ====
`timescale 1ns/1ps
`include "ram_cfg.svh"

module prog_ram_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   rx_i,
  input  ram_pkg::mem_wr_t       cpu_wr_i,
  input  ram_pkg::mem_rd_t       cpu_rd_i,
  output logic [`RAM_DATA_W-1:0] rd_data_o,
  output logic                   prog_mode_o,
  output logic                   sys_rst_no
);

  prog_pkg::rx_byte_t rx_byte;
  ram_pkg::mem_wr_t   prog_wr;

  // Serial line to byte strobes
  uart_rx uart_rx_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .rx_i   (rx_i),
    .byte_o (rx_byte)
  );

  // Magic detect and word writes
  prog_loader prog_loader_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .byte_i      (rx_byte),
    .wr_o        (prog_wr),
    .prog_mode_o (prog_mode_o),
    .sys_rst_no  (sys_rst_no)
  );

  prog_ram prog_ram_inst (
    .clk_i     (clk_i),
    .cpu_wr_i  (cpu_wr_i),
    .prog_wr_i (prog_wr),
    .cpu_rd_i  (cpu_rd_i),
    .rd_data_o (rd_data_o)
  );

endmodule

// ==== hdl/ram_cfg.svh ====
`ifndef RAM_CFG_SVH
`define RAM_CFG_SVH

//////////////////////////////
// RAM geometry
//////////////////////////////

// Word address width, depth is 2**RAM_ADDR_W words
`define RAM_ADDR_W 10

// Byte columns per word and bits per column
`define RAM_NB_COL 4
`define RAM_COL_W 8

// Full word width
`define RAM_DATA_W (`RAM_NB_COL * `RAM_COL_W)

//////////////////////////////
// Serial loader
//////////////////////////////

// Clock cycles per serial bit, clock frequency over baud rate on a board
`define UART_CLKS_PER_BIT 8

// Magic sequence that opens a load
`define PROG_MAGIC "TEKNOFEST"
`define PROG_MAGIC_LEN 9

// Idle cycles inside the magic before it is abandoned
`define PROG_BREAK_CYCLES 2000

`endif

// ==== hdl/ram_pkg.sv ====
`include "ram_cfg.svh"

package ram_pkg;

  //////////////////////////////
  // Memory port types
  //////////////////////////////

  // Byte-strobed write, used by the CPU and the loader
  // No strobe bit set means no write this cycle
  typedef struct packed {
    logic [`RAM_ADDR_W-1:0] addr;
    logic [`RAM_DATA_W-1:0] data;
    logic [`RAM_NB_COL-1:0] strb;
  } mem_wr_t;

  // Word read request
  // Data returns one clock after en
  typedef struct packed {
    logic                   en;
    logic [`RAM_ADDR_W-1:0] addr;
  } mem_rd_t;

endpackage

// ==== hdl/uart_rx.sv ====
`timescale 1ns/1ps
`include "ram_cfg.svh"

module uart_rx (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               rx_i,
  output prog_pkg::rx_byte_t byte_o
);

  localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(`UART_CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(`UART_CLKS_PER_BIT / 2 - 1);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  logic             rx_meta;
  logic             rx_sync;
  rx_state_e        state_q;
  logic [CNT_W-1:0] cnt_q;
  logic [2:0]       bit_idx_q;
  logic [7:0]       data_q;
  logic             valid_q;

  // Two-flop synchronizer, line idles high
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx_i;
      rx_sync <= rx_meta;
    end
  end

  //////////////////////////////
  // Frame FSM
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q   <= RX_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          cnt_q <= '0;
          if (!rx_sync) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          // Start bit must still be low at mid-bit
          if (cnt_q == HALF_LAST) begin
            cnt_q     <= '0;
            bit_idx_q <= '0;
            state_q   <= rx_sync ? RX_IDLE : RX_DATA;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RX_DATA: begin
          if (cnt_q == BIT_LAST) begin
            cnt_q <= '0;
            if (bit_idx_q == 3'd7) begin
              state_q <= RX_STOP;
            end else begin
              bit_idx_q <= bit_idx_q + 1'b1;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RX_STOP: begin
          // Framing error drops the byte
          if (cnt_q == BIT_LAST) begin
            valid_q <= rx_sync;
            state_q <= RX_IDLE;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge clk_i) begin
    if (state_q == RX_DATA && cnt_q == BIT_LAST) begin
      data_q <= {rx_sync, data_q[7:1]};
    end
  end

  assign byte_o = '{valid: valid_q, data: data_q};

  // Frames are many cycles long, so strobes never touch
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    byte_o.valid |=> !byte_o.valid);

endmodule
